// File: hw/panel_pkg.sv
// shared types and opcodes for the LED panel command controller
// panel is 4 rows by 4 columns at 2 bytes per pixel, so the frame RAM is 32 bytes
`default_nettype none

package panel_pkg;

    // panel geometry
    localparam int panel_rows        = 4;
    localparam int panel_cols        = 4;
    localparam int bytes_per_pixel   = 2;
    localparam int brightness_levels = 6;
    localparam int ram_depth         = panel_rows * panel_cols * bytes_per_pixel;

    typedef logic [7:0]                         byte_t;
    typedef logic [$clog2(panel_rows)-1:0]      row_addr_t;
    typedef logic [$clog2(panel_cols)-1:0]      col_addr_t;
    typedef logic [0:0]                         pixel_sel_t;
    // row, column, pixel byte from msb to lsb
    typedef logic [$clog2(ram_depth)-1:0]       ram_addr_t;
    typedef logic [brightness_levels-1:0]       brightness_t;
    // bit 0 red, bit 1 green, bit 2 blue
    typedef logic [2:0]                         rgb_t;

    typedef enum logic [1:0] {
        st_idle,
        st_write_pixel,
        st_blank
    } ctrl_state_t;

    // colour channel opcodes
    localparam byte_t op_red_on    = 8'h01;
    localparam byte_t op_red_off   = 8'h02;
    localparam byte_t op_green_on  = 8'h03;
    localparam byte_t op_green_off = 8'h04;
    localparam byte_t op_blue_on   = 8'h05;
    localparam byte_t op_blue_off  = 8'h06;

    // brightness opcodes, 0x11 toggles the top plane
    localparam byte_t op_bright_zero        = 8'h10;
    localparam byte_t op_bright_toggle_base = 8'h11;
    localparam byte_t op_bright_full        = 8'h19;

    // memory opcodes
    localparam byte_t op_blank_panel = 8'h20;
    localparam byte_t op_write_pixel = 8'h21;

endpackage

`default_nettype wire

// File: hw/cmd_decoder.sv
// opcode decoder and command FSM, no back-pressure on data_valid
// opcodes are only decoded while idle, bytes strobed during a blank are dropped
`default_nettype none

module cmd_decoder (
    input  logic                   clk_in,
    input  logic                   reset,
    input  panel_pkg::byte_t       data_rx,
    input  logic                   data_valid,
    input  logic                   pixel_done,
    input  logic                   blank_done,
    output logic                   arg_valid,
    output panel_pkg::byte_t       arg_data,
    output logic                   blank_start,
    output panel_pkg::rgb_t        rgb_enable,
    output panel_pkg::brightness_t brightness_enable,
    output logic                   busy
);
    import panel_pkg::*;

    ctrl_state_t state;
    brightness_t toggle_mask;
    logic        cmd_ready;

    // the blank sweep hands back control in its done cycle
    assign cmd_ready = (state == st_idle) || blank_done;
    assign busy      = ~cmd_ready;

    // argument bytes only reach the pixel writer while it owns the stream
    assign arg_valid = data_valid && (state == st_write_pixel);
    assign arg_data  = data_rx;

    // one-hot plane select for the toggle opcodes
    always_comb begin
        toggle_mask = '0;
        for (int i = 0; i < brightness_levels; i++) begin
            if (data_rx == op_bright_toggle_base + byte_t'(i)) begin
                toggle_mask[brightness_levels-1-i] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state             <= st_idle;
            blank_start       <= 1'b0;
            rgb_enable        <= '1;
            brightness_enable <= '1;
        end else begin
            blank_start <= 1'b0;

            if (pixel_done || blank_done) begin
                state <= st_idle;
            end

            if (cmd_ready && data_valid) begin
                case (data_rx)
                    op_red_on: begin
                        rgb_enable[0] <= 1'b1;
                    end
                    op_red_off: begin
                        rgb_enable[0] <= 1'b0;
                    end
                    op_green_on: begin
                        rgb_enable[1] <= 1'b1;
                    end
                    op_green_off: begin
                        rgb_enable[1] <= 1'b0;
                    end
                    op_blue_on: begin
                        rgb_enable[2] <= 1'b1;
                    end
                    op_blue_off: begin
                        rgb_enable[2] <= 1'b0;
                    end
                    op_bright_zero: begin
                        brightness_enable <= '0;
                    end
                    op_bright_full: begin
                        brightness_enable <= '1;
                    end
                    op_blank_panel: begin
                        state       <= st_blank;
                        blank_start <= 1'b1;
                    end
                    op_write_pixel: begin
                        state <= st_write_pixel;
                    end
                    default: begin
                        // mask is zero for unknown opcodes
                        brightness_enable <= brightness_enable ^ toggle_mask;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/pixel_writer.sv
// collects row, column and the pixel data bytes of a write pixel command
// only the low bits of row and column are used, data bytes land in reverse order
`default_nettype none

module pixel_writer (
    input  logic                 clk_in,
    input  logic                 reset,
    input  logic                 arg_valid,
    input  panel_pkg::byte_t     arg_data,
    output logic                 write_enable,
    output panel_pkg::ram_addr_t write_address,
    output panel_pkg::byte_t     write_data,
    output logic                 done
);
    import panel_pkg::*;

    localparam int last_arg = 1 + bytes_per_pixel;

    logic [1:0] arg_index;
    row_addr_t  row_q;
    col_addr_t  col_q;
    pixel_sel_t data_index;
    pixel_sel_t byte_index;
    logic       is_data;
    logic       is_last;

    assign is_data    = arg_index >= 2'd2;
    assign is_last    = arg_index == 2'(last_arg);
    assign data_index = pixel_sel_t'(arg_index - 2'd2);
    // first data byte goes to the highest byte index
    assign byte_index = pixel_sel_t'(bytes_per_pixel - 1) - data_index;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            arg_index    <= '0;
            write_enable <= 1'b0;
            done         <= 1'b0;
        end else begin
            write_enable <= arg_valid && is_data;
            done         <= arg_valid && is_last;
            if (arg_valid) begin
                if (is_last) begin
                    arg_index <= '0;
                end else begin
                    arg_index <= arg_index + 2'd1;
                end
            end
        end
    end

    // row and column latches plus the write payload
    always_ff @(posedge clk_in) begin
        if (arg_valid) begin
            case (arg_index)
                2'd0: row_q <= arg_data[$bits(row_addr_t)-1:0];
                2'd1: col_q <= arg_data[$bits(col_addr_t)-1:0];
                default: begin
                    write_address <= {row_q, col_q, byte_index};
                    write_data    <= arg_data;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/panel_blanker.sv
// writes zero to every frame RAM address, one per cycle in ascending order
// done pulses the cycle after the last write
`default_nettype none

module panel_blanker (
    input  logic                 clk_in,
    input  logic                 reset,
    input  logic                 start,
    output logic                 write_enable,
    output panel_pkg::ram_addr_t write_address,
    output panel_pkg::byte_t     write_data,
    output logic                 done
);
    import panel_pkg::*;

    localparam ram_addr_t last_address = ram_addr_t'(ram_depth - 1);

    assign write_data = '0;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            write_enable  <= 1'b0;
            write_address <= '0;
            done          <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                write_enable  <= 1'b1;
                write_address <= '0;
            end else if (write_enable) begin
                if (write_address == last_address) begin
                    write_enable <= 1'b0;
                    done         <= 1'b1;
                end else begin
                    write_address <= write_address + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/panel_control.sv
// LED panel command controller top, one command byte per data_valid strobe
// wait for busy low before sending an opcode, the RAM port is write only
`default_nettype none

module panel_control (
    input  logic                   clk_in,
    input  logic                   reset,
    input  panel_pkg::byte_t       data_rx,
    input  logic                   data_valid,
    output panel_pkg::rgb_t        rgb_enable,
    output panel_pkg::brightness_t brightness_enable,
    output panel_pkg::ram_addr_t   ram_address,
    output panel_pkg::byte_t       ram_data,
    output logic                   ram_write_enable,
    output logic                   busy
);
    import panel_pkg::*;

    logic      arg_valid;
    byte_t     arg_data;
    logic      blank_start;
    logic      pixel_we;
    ram_addr_t pixel_addr;
    byte_t     pixel_data;
    logic      pixel_done;
    logic      blank_we;
    ram_addr_t blank_addr;
    byte_t     blank_data;
    logic      blank_done;

    cmd_decoder u_decoder (
        .clk_in            (clk_in),
        .reset             (reset),
        .data_rx           (data_rx),
        .data_valid        (data_valid),
        .pixel_done        (pixel_done),
        .blank_done        (blank_done),
        .arg_valid         (arg_valid),
        .arg_data          (arg_data),
        .blank_start       (blank_start),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable),
        .busy              (busy)
    );

    pixel_writer u_pixel_writer (
        .clk_in        (clk_in),
        .reset         (reset),
        .arg_valid     (arg_valid),
        .arg_data      (arg_data),
        .write_enable  (pixel_we),
        .write_address (pixel_addr),
        .write_data    (pixel_data),
        .done          (pixel_done)
    );

    panel_blanker u_blanker (
        .clk_in        (clk_in),
        .reset         (reset),
        .start         (blank_start),
        .write_enable  (blank_we),
        .write_address (blank_addr),
        .write_data    (blank_data),
        .done          (blank_done)
    );

    // writers never overlap, blanker wins the port while it writes
    assign ram_write_enable = blank_we | pixel_we;
    assign ram_address      = blank_we ? blank_addr : pixel_addr;
    assign ram_data         = blank_we ? blank_data : pixel_data;

endmodule

`default_nettype wire

// File: bench/panel_control_properties.sv
// control output checks bound into panel_control
// blank_active follows the decoder's blank state inside the top level
`default_nettype none

module panel_control_properties (
    input logic             clk_in,
    input logic             reset,
    input logic             busy,
    input logic             ram_write_enable,
    input panel_pkg::byte_t ram_data,
    input logic             blank_active
);

    write_needs_busy: assert property (@(posedge clk_in) disable iff (reset)
        ram_write_enable |-> busy)
        else $error("RAM write strobe seen while busy is low");

    idle_after_reset: assert property (@(posedge clk_in)
        reset |=> !busy)
        else $error("busy high in the cycle after reset");

    blank_writes_zero: assert property (@(posedge clk_in) disable iff (reset)
        (blank_active && ram_write_enable) |-> (ram_data == '0))
        else $error("non-zero RAM data during a blank sweep");

endmodule

bind panel_control panel_control_properties u_properties (
    .clk_in           (clk_in),
    .reset            (reset),
    .busy             (busy),
    .ram_write_enable (ram_write_enable),
    .ram_data         (ram_data),
    .blank_active     (u_decoder.state == panel_pkg::st_blank)
);

`default_nettype wire

// File: bench/tb_panel_control.sv
// testbench for panel_control: opcode table, random pixel writes and a blank sweep
// frame RAM is modelled from the write strobes, sampled on the falling edge
`default_nettype none

module tb_panel_control;
    import panel_pkg::*;

    localparam int n_steps     = 25;
    localparam int idle_limit  = 100;
    localparam int pixel_count = 6;

    logic        clk_in;
    logic        reset;
    byte_t       data_rx;
    logic        data_valid;
    rgb_t        rgb_enable;
    brightness_t brightness_enable;
    ram_addr_t   ram_address;
    byte_t       ram_data;
    logic        ram_write_enable;
    logic        busy;

    byte_t     model_ram [ram_depth];
    byte_t     expect_ram [ram_depth];
    ram_addr_t write_addr_q [$];
    byte_t     write_data_q [$];
    int        errors;
    int        checks;

    // opcode, expected rgb_enable, expected brightness_enable
    logic [16:0] step_table [n_steps] = '{
        {8'h02, 3'b110, 6'b111111}, {8'h04, 3'b100, 6'b111111},
        {8'h01, 3'b101, 6'b111111}, {8'h06, 3'b001, 6'b111111},
        {8'h03, 3'b011, 6'b111111}, {8'h05, 3'b111, 6'b111111},
        {8'h7f, 3'b111, 6'b111111}, {8'h11, 3'b111, 6'b011111},
        {8'h11, 3'b111, 6'b111111}, {8'h16, 3'b111, 6'b111110},
        {8'h13, 3'b111, 6'b110110}, {8'h16, 3'b111, 6'b110111},
        {8'h13, 3'b111, 6'b111111}, {8'h10, 3'b111, 6'b000000},
        {8'h12, 3'b111, 6'b010000}, {8'h14, 3'b111, 6'b010100},
        {8'h15, 3'b111, 6'b010110}, {8'h15, 3'b111, 6'b010100},
        {8'h14, 3'b111, 6'b010000}, {8'h12, 3'b111, 6'b000000},
        {8'h17, 3'b111, 6'b000000}, {8'hff, 3'b111, 6'b000000},
        {8'h19, 3'b111, 6'b111111}, {8'h02, 3'b110, 6'b111111},
        {8'h16, 3'b110, 6'b111110}
    };

    panel_control DUT (
        .clk_in            (clk_in),
        .reset             (reset),
        .data_rx           (data_rx),
        .data_valid        (data_valid),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable),
        .ram_address       (ram_address),
        .ram_data          (ram_data),
        .ram_write_enable  (ram_write_enable),
        .busy              (busy)
    );

    initial begin
        clk_in = 1'b0;
        forever #50 clk_in = ~clk_in;
    end

    always @(negedge clk_in) begin
        if (ram_write_enable === 1'b1) begin
            model_ram[ram_address] = ram_data;
            write_addr_q.push_back(ram_address);
            write_data_q.push_back(ram_data);
        end
    end

    task automatic check(input string name, input logic [31:0] got,
                         input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("Mismatch %s: got 0x%0h, expected 0x%0h at %0t",
                     name, got, expected, $time);
        end
    endtask

    task automatic finish_run();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    endtask

    // called 10 units after a rising edge, returns at the same offset
    task automatic send_byte(input byte_t value);
        data_rx    = value;
        data_valid = 1'b1;
        @(posedge clk_in);
        #10;
        data_valid = 1'b0;
    endtask

    task automatic wait_cycles(input int count);
        repeat (count) begin
            @(posedge clk_in);
            #10;
        end
    endtask

    task automatic wait_idle(input int limit);
        int cycles;
        cycles = 0;
        while (busy !== 1'b0 && cycles < limit) begin
            @(posedge clk_in);
            #10;
            cycles++;
        end
        if (busy !== 1'b0) begin
            errors++;
            $display("Timeout: busy still high after %0d cycles", limit);
            finish_run();
        end
    endtask

    task automatic clear_log();
        write_addr_q.delete();
        write_data_q.delete();
    endtask

    task automatic compare_ram();
        int a;
        for (a = 0; a < ram_depth; a++) begin
            check($sformatf("ram[%0d]", a), 32'(model_ram[a]), 32'(expect_ram[a]));
        end
    endtask

    task automatic write_random_pixel();
        int    row;
        int    col;
        int    base;
        int    k;
        byte_t pix [bytes_per_pixel];
        row  = $urandom() % 256;
        col  = $urandom() % 256;
        // upper bits of row and column are ignored by the layout
        base = (row % panel_rows) * panel_cols * bytes_per_pixel
             + (col % panel_cols) * bytes_per_pixel;
        for (k = 0; k < bytes_per_pixel; k++) begin
            pix[k] = byte_t'($urandom());
        end
        clear_log();
        send_byte(op_write_pixel);
        check("busy", 32'(busy), 32'(1));
        send_byte(byte_t'(row));
        send_byte(byte_t'(col));
        for (k = 0; k < bytes_per_pixel; k++) begin
            send_byte(pix[k]);
        end
        wait_idle(idle_limit);
        check("write count", 32'(write_addr_q.size()), 32'(bytes_per_pixel));
        for (k = 0; k < bytes_per_pixel && k < write_addr_q.size(); k++) begin
            check("ram_address", 32'(write_addr_q[k]), 32'(base + bytes_per_pixel - 1 - k));
            check("ram_data", 32'(write_data_q[k]), 32'(pix[k]));
        end
        for (k = 0; k < bytes_per_pixel; k++) begin
            expect_ram[base + bytes_per_pixel - 1 - k] = pix[k];
        end
    endtask

    initial begin
        int step;
        int i;
        void'($urandom(21));
        errors     = 0;
        checks     = 0;
        reset      = 1'b1;
        data_rx    = '0;
        data_valid = 1'b0;
        for (i = 0; i < ram_depth; i++) begin
            model_ram[i]  = byte_t'(32'h5a ^ (i * 37));
            expect_ram[i] = byte_t'(32'h5a ^ (i * 37));
        end
        repeat (8) @(posedge clk_in);
        #10;
        reset = 1'b0;

        check("rgb_enable", 32'(rgb_enable), 32'(3'b111));
        check("brightness_enable", 32'(brightness_enable), 32'(6'b111111));
        check("busy", 32'(busy), 32'(0));
        check("write count", 32'(write_addr_q.size()), 32'(0));

        for (step = 0; step < n_steps; step++) begin
            clear_log();
            send_byte(step_table[step][16:9]);
            check("busy", 32'(busy), 32'(0));
            wait_idle(idle_limit);
            check("rgb_enable", 32'(rgb_enable), 32'(step_table[step][8:6]));
            check("brightness_enable", 32'(brightness_enable), 32'(step_table[step][5:0]));
            check("write count", 32'(write_addr_q.size()), 32'(0));
        end

        for (i = 0; i < pixel_count; i++) begin
            write_random_pixel();
        end
        compare_ram();

        // red on arrives mid sweep and must be dropped
        clear_log();
        send_byte(op_blank_panel);
        check("busy", 32'(busy), 32'(1));
        wait_cycles(4);
        send_byte(op_red_on);
        wait_idle(idle_limit);
        check("rgb_enable", 32'(rgb_enable), 32'(step_table[n_steps-1][8:6]));
        check("write count", 32'(write_addr_q.size()), 32'(ram_depth));
        for (i = 0; i < write_addr_q.size(); i++) begin
            check("ram_address", 32'(write_addr_q[i]), 32'(i));
            check("ram_data", 32'(write_data_q[i]), 32'(0));
        end
        for (i = 0; i < ram_depth; i++) begin
            expect_ram[i] = '0;
        end
        compare_ram();

        write_random_pixel();
        compare_ram();
        finish_run();
    end

endmodule

`default_nettype wire

// File: sim.f
hw/panel_pkg.sv
hw/cmd_decoder.sv
hw/pixel_writer.sv
hw/panel_blanker.sv
hw/panel_control.sv
bench/panel_control_properties.sv
bench/tb_panel_control.sv

// File: Makefile
# Verilator build and run for the panel_control testbench

VERILATOR ?= verilator
TOP       ?= tb_panel_control
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BINARY) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qF '*** FAILED ***' $(LOG); then echo "simulation reported errors"; exit 1; fi
	@grep -qF '*** PASSED ***' $(LOG) || (echo "simulation ended early"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
